//--- include/tinker_defs.svh
`ifndef TINKER_DEFS_SVH
`define TINKER_DEFS_SVH

// datapath widths
`define TINKER_DATA_W  64
`define TINKER_ADDR_W  32
`define TINKER_REG_W   5
`define TINKER_LIT_W   12
`define TINKER_INSTR_W 32

`define TINKER_PC_RESET  32'h0000_2000          // first fetch address
`define TINKER_STACK_TOP 64'h0000_0000_0008_0000 // r31 after reset
`define TINKER_MEM_BYTES 65536                   // 64 KB is plenty for tests
`define TINKER_NOP       32'h8800_0000           // mov r0, r0

// opcodes sit in bits 31:27 of the instruction
`define TINKER_OP_AND    5'h00
`define TINKER_OP_OR     5'h01
`define TINKER_OP_XOR    5'h02
`define TINKER_OP_NOT    5'h03
`define TINKER_OP_SHFTR  5'h04
`define TINKER_OP_SHFTRI 5'h05
`define TINKER_OP_SHFTL  5'h06
`define TINKER_OP_SHFTLI 5'h07
`define TINKER_OP_BR     5'h08
`define TINKER_OP_BRR_R  5'h09
`define TINKER_OP_BRR_L  5'h0a
`define TINKER_OP_BRNZ   5'h0b
`define TINKER_OP_BRGT   5'h0e
`define TINKER_OP_HALT   5'h0f
`define TINKER_OP_LOAD   5'h10 // mov rd, (rs)(L)
`define TINKER_OP_MOV_RR 5'h11
`define TINKER_OP_MOV_RL 5'h12
`define TINKER_OP_STORE  5'h13 // mov (rd)(L), rs
`define TINKER_OP_ADD    5'h18
`define TINKER_OP_ADDI   5'h19
`define TINKER_OP_SUB    5'h1a
`define TINKER_OP_SUBI   5'h1b
`define TINKER_OP_MUL    5'h1c

`endif

//--- list.f
+incdir+include
source/tinker_pkg.sv
source/run_control.sv
source/pc_counter.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/unified_memory.sv
source/tinker_core.sv
sim/tb_tinker_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tinker core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_tinker_core \
    -f list.f -o tb_sim > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    echo "build or run error, see build.log and sim.log"

grep -q "^Result: PASSED$" sim.log 2>/dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

//--- sim/tb_tinker_core.sv
`timescale 1ns/1ps

module tb_tinker_core import tinker_pkg::*; ();
    logic        clk;
    logic        reset;
    prog_write_t prog;
    logic        start;
    commit_t     commit;
    logic        halted;

    instr_t   word_q[$];   // all programs back to back
    reg_num_t cdest_q[$];  // expected commit stream
    word_t    cval_q[$];
    string    name_q[$];
    int       ninstr_q[$];
    int       ncommit_q[$];

    int error_count;
    int fail_tests;
    int cycle_count;
    int cycle_limit;       // 0 until the test file is read

    tinker_core i_tinker_core (
        .clk    (clk),
        .reset  (reset),
        .prog   (prog),
        .start  (start),
        .commit (commit),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.dest !== exp.dest) begin
            $display("** Error at %0t ns: commit.dest got %0d expected %0d",
                     $time, got.dest, exp.dest);
            error_count++;
        end
        if (got.value !== exp.value) begin
            $display("** Error at %0t ns: commit.value got %h expected %h",
                     $time, got.value, exp.value);
            error_count++;
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: halted got %b expected %b", $time, got, exp);
            error_count++;
        end
    endtask

    // reset, load, start, then follow commits until halted
    task automatic run_test(input int t, input int ibase, input int cbase);
        int      got_n;
        int      errs_before;
        commit_t exp;
        errs_before = error_count;
        got_n = 0;
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int k = 0; k < ninstr_q[t]; k++) begin
            @(posedge clk);
            prog <= '{valid: 1'b1, addr: addr_t'(k), instr: word_q[ibase + k]};
        end
        @(negedge clk);
        check_halt(halted, 1'b0); // still in load_s
        @(posedge clk);
        prog  <= '0;
        start <= 1'b1; // one cycle pulse
        @(posedge clk);
        start <= 1'b0;
        while (!halted) begin
            @(negedge clk); // outputs settled mid cycle
            if (commit.valid) begin
                if (got_n < ncommit_q[t]) begin
                    exp.valid = 1'b1;
                    exp.dest  = cdest_q[cbase + got_n];
                    exp.value = cval_q[cbase + got_n];
                    check_commit(commit, exp);
                end else begin
                    $display("unexpected extra commit to r%0d at %0t ns", commit.dest, $time);
                    error_count++;
                end
                got_n++;
            end
        end
        repeat (3) begin
            @(negedge clk);
            if (commit.valid) begin
                $display("commit to r%0d seen after halt at %0t ns", commit.dest, $time);
                error_count++;
            end
        end
        check_halt(halted, 1'b1);
        if (got_n != ncommit_q[t]) begin
            $display("%s saw %0d commits but expected %0d", name_q[t], got_n, ncommit_q[t]);
            error_count++;
        end
        if (error_count == errs_before) begin
            $display("test %s: ok, %0d commits", name_q[t], got_n);
        end else begin
            $display("test %s: failed with %0d errors", name_q[t], error_count - errs_before);
            fail_tests++;
        end
    endtask

    initial begin
        int     fd;
        int     ni;
        int     nc;
        int     total;
        int     ibase;
        int     cbase;
        string  tname;
        string  line;
        instr_t w;
        int     d;
        word_t  v;
        reset       = 1'b1;
        prog        = '0;
        start       = 1'b0;
        error_count = 0;
        fail_tests  = 0;
        cycle_count = 0;
        cycle_limit = 0;
        total       = 0;
        fd = $fopen("sim/tinker_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/tinker_tests.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            void'($fgets(line, fd)); // two column description lines
            void'($fgets(line, fd));
            while ($fscanf(fd, "%s %d %d", tname, ni, nc) == 3) begin
                name_q.push_back(tname);
                ninstr_q.push_back(ni);
                ncommit_q.push_back(nc);
                total += ni;
                for (int k = 0; k < ni; k++) begin
                    void'($fscanf(fd, "%h", w));
                    word_q.push_back(w);
                end
                for (int k = 0; k < nc; k++) begin
                    void'($fscanf(fd, "%h %h", d, v));
                    cdest_q.push_back(reg_num_t'(d));
                    cval_q.push_back(v);
                end
            end
            $fclose(fd);
            cycle_limit = 10 * total + 50 * name_q.size();
            ibase = 0;
            cbase = 0;
            for (int t = 0; t < name_q.size(); t++) begin
                run_test(t, ibase, cbase);
                ibase += ninstr_q[t];
                cbase += ncommit_q[t];
            end
            $display("tests: %0d run, %0d failed, %0d errors",
                     name_q.size(), fail_tests, error_count);
            if (error_count == 0 && name_q.size() > 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

//--- sim/tinker_tests.txt
# per test: name, instruction count, commit count, then instruction words (hex)
# then expected commits as destination and value pairs (hex)
arith_fwd 15 13
90400005 90800003 c0c22000 e1061000 d1482000
39400004 118a4000 19cc0000 020e6000 0a4e5000
228a2000 8ad40000 dac00002 78000000 c8400001
1 5  2 3  3 8  4 28  5 25  5 250  6 278  7 fffffffffffffd87
8 0  9 ffffffffffffffd7  a 4a  b 4a  b 48
store_load_use 6 4
90400100 9080007a 98440008 80c20008 c1063000 78000000
1 100  2 7a  3 7a  4 f4
branch_r0_r31 22 9
90400001 9080080a 38800002 92400813 3a400002 c0c1f000
c8000009 58820000 91000bad 91000bad c1401000 72401000
91800011 50000003 91c00bad 91c00bad 72420000 92000bad
92000bad c2ca6000 78000000 93000bad
1 1  2 80a  2 2028  9 813  9 204c  3 80000  5 1  6 11  b 12

//--- source/decode_stage.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module decode_stage import tinker_pkg::*; (
    input  instr_t   instr,
    input  addr_t    pc,
    input  word_t    rd_val,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  reg_num_t ex_load_dest,
    input  logic     ex_is_load,
    output idex_t    fields,
    output logic     stall,
    output logic     taken,
    output addr_t    target
);
    opcode_t  opcode;
    reg_num_t rd;
    reg_num_t rs;
    reg_num_t rt;
    literal_t literal;
    ctrl_t    ctrl;
    logic     reads_rd;   // rd is also a source operand
    addr_t    lit_offset; // brr L displacement

    assign opcode  = opcode_t'(instr[31:27]);
    assign rd      = instr[26:22];
    assign rs      = instr[21:17];
    assign rt      = instr[16:12];
    assign literal = instr[11:0];

    // sign-extended literal times four
    assign lit_offset = {{(`TINKER_ADDR_W - `TINKER_LIT_W - 2){literal[`TINKER_LIT_W-1]}},
                         literal, 2'b00};

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_add, op_addi, op_sub, op_subi, op_mul,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_rr, op_mov_rl: begin
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_store: ctrl.mem_write = 1'b1;
            op_halt:  ctrl.halt = 1'b1;
            default:  ctrl = '0; // branches and unknown codes write nothing
        endcase
    end

    always_comb begin
        case (opcode)
            op_addi, op_subi, op_shftri, op_shftli, op_mov_rl, op_store: reads_rd = 1'b1;
            default: reads_rd = 1'b0;
        endcase
    end

    // load result is only ready after MEM, so hold one cycle
    assign stall = ex_is_load && (ex_load_dest != '0) &&
                   ((ex_load_dest == rs) || (ex_load_dest == rt) ||
                    (reads_rd && (ex_load_dest == rd)));

    // early branch decision on raw register values
    always_comb begin
        taken  = 1'b0;
        target = pc + addr_t'(4);
        case (opcode)
            op_br: begin
                taken  = 1'b1;
                target = rd_val[`TINKER_ADDR_W-1:0];
            end
            op_brr_r: begin
                taken  = 1'b1;
                target = pc + rd_val[`TINKER_ADDR_W-1:0];
            end
            op_brr_l: begin
                taken  = 1'b1;
                target = pc + lit_offset;
            end
            op_brnz: begin
                taken  = (rs_val != '0);
                target = rd_val[`TINKER_ADDR_W-1:0];
            end
            op_brgt: begin
                taken  = ($signed(rs_val) > $signed(rt_val)); // signed compare
                target = rd_val[`TINKER_ADDR_W-1:0];
            end
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        fields.ctrl    = ctrl;
        fields.opcode  = opcode;
        fields.rd      = rd;
        fields.rs      = rs;
        fields.rt      = rt;
        fields.literal = literal;
        fields.rd_val  = rd_val;
        fields.rs_val  = rs_val;
        fields.rt_val  = rt_val;
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module execute_stage import tinker_pkg::*; (
    input  idex_t    idex,
    input  reg_num_t exmem_dest,
    input  reg_num_t memwb_dest,
    input  logic     exmem_wr,
    input  logic     memwb_wr,
    input  word_t    exmem_result,
    input  word_t    wb_value,
    output word_t    result,
    output word_t    store_data
);
    word_t rd_op;
    word_t rs_op;
    word_t rt_op;
    word_t lit_zx; // ALU literal forms
    word_t lit_sx; // memory offsets

    // youngest producer wins and r0 is never forwarded
    function automatic word_t pick(input reg_num_t num, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (exmem_wr && (exmem_dest != '0) && (exmem_dest == num)) begin
            val = exmem_result;
        end else if (memwb_wr && (memwb_dest != '0) && (memwb_dest == num)) begin
            val = wb_value;
        end
        return val;
    endfunction

    always_comb begin
        rd_op = pick(idex.rd, idex.rd_val);
        rs_op = pick(idex.rs, idex.rs_val);
        rt_op = pick(idex.rt, idex.rt_val);
    end

    assign lit_zx = word_t'(idex.literal);
    assign lit_sx = {{(`TINKER_DATA_W - `TINKER_LIT_W){idex.literal[`TINKER_LIT_W-1]}},
                     idex.literal};

    // source of mov (rd)(L), rs is the second operand
    assign store_data = rs_op;

    always_comb begin
        case (idex.opcode)
            op_add:    result = rs_op + rt_op;
            op_addi:   result = rd_op + lit_zx; // rd is source and dest
            op_sub:    result = rs_op - rt_op;
            op_subi:   result = rd_op - lit_zx;
            op_mul:    result = rs_op * rt_op;  // low 64 bits
            op_and:    result = rs_op & rt_op;
            op_or:     result = rs_op | rt_op;
            op_xor:    result = rs_op ^ rt_op;
            op_not:    result = ~rs_op;
            op_shftr:  result = rs_op >> rt_op;
            op_shftri: result = rd_op >> idex.literal;
            op_shftl:  result = rs_op << rt_op;
            op_shftli: result = rd_op << idex.literal;
            op_mov_rr: result = rs_op;
            op_mov_rl: result = {rd_op[`TINKER_DATA_W-1:`TINKER_LIT_W], idex.literal};
            op_load:   result = rs_op + lit_sx; // effective address
            op_store:  result = rd_op + lit_sx;
            default:   result = '0;
        endcase
    end

endmodule

//--- source/pc_counter.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module pc_counter import tinker_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  run_en,
    input  logic  stall,
    input  logic  taken,
    input  addr_t target,
    output addr_t pc
);
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `TINKER_PC_RESET;
        end else if (run_en && !stall) begin // load-use hold wins over redirect
            if (taken) begin
                pc <= target;
            end else begin
                pc <= pc + addr_t'(4);
            end
        end
    end

    // branch targets come from register values, so a bad program shows up here
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module reg_file import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_num_t wr_num,
    input  word_t    wr_data,
    input  reg_num_t rd_num,
    input  reg_num_t rs_num,
    input  reg_num_t rt_num,
    output word_t    rd_val,
    output word_t    rs_val,
    output word_t    rt_val
);
    localparam int NUM_REGS = 1 << `TINKER_REG_W;

    word_t regs [NUM_REGS];

    // r0 is hardwired, WB data bypasses the array
    function automatic word_t read_port(input reg_num_t num);
        word_t val;
        if (num == '0) begin
            val = '0;
        end else if (we && (wr_num == num)) begin
            val = wr_data;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_comb begin
        rd_val = read_port(rd_num);
        rs_val = read_port(rs_num);
        rt_val = read_port(rt_num);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
            regs[NUM_REGS-1] <= `TINKER_STACK_TOP; // r31 is the stack pointer
        end else if (we && (wr_num != '0)) begin
            regs[wr_num] <= wr_data;
        end
    end

endmodule

//--- source/run_control.sv
`timescale 1ns/1ps

module run_control import tinker_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic wb_halt,
    output logic run_en,
    output logic halted
);
    run_state_t state;
    run_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            load_s: begin
                if (start) begin
                    state_next = run_s; // memory is filled, go
                end
            end
            run_s: begin
                if (wb_halt) begin
                    state_next = halted_s; // halt reached writeback
                end
            end
            default: begin
                state_next = state; // halted until reset
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= load_s;
        end else begin
            state <= state_next;
        end
    end

    assign run_en = (state == run_s);
    assign halted = (state == halted_s);

    // testbench may only start a loaded, idle core
    a_start_in_load: assert property (@(posedge clk) disable iff (reset)
        start |-> state == load_s)
        else $error("start seen outside load_s");

endmodule

//--- source/tinker_core.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module tinker_core import tinker_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  prog_write_t prog,
    input  logic        start,
    output commit_t     commit,
    output logic        halted
);
    logic   run_en;
    logic   stall;
    logic   taken;
    addr_t  target;
    addr_t  pc;
    instr_t fetch_instr;
    instr_t ifid_instr;
    addr_t  ifid_pc;
    idex_t  id_fields;
    idex_t  idex_q;
    exmem_t exmem_q;
    memwb_t memwb_q;
    word_t  rf_rd_val;
    word_t  rf_rs_val;
    word_t  rf_rt_val;
    word_t  ex_result;
    word_t  ex_store_data;
    word_t  load_data;
    word_t  wb_value;
    logic   rf_we;

    run_control i_run_control (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .wb_halt (memwb_q.ctrl.halt),
        .run_en  (run_en),
        .halted  (halted)
    );

    pc_counter i_pc_counter (
        .clk    (clk),
        .reset  (reset),
        .run_en (run_en),
        .stall  (stall),
        .taken  (taken),
        .target (target),
        .pc     (pc)
    );

    unified_memory i_unified_memory (
        .clk        (clk),
        .prog       (prog),
        .fetch_addr (pc),
        .instr      (fetch_instr),
        .data_addr  (exmem_q.result[`TINKER_ADDR_W-1:0]),
        .store_en   (exmem_q.ctrl.mem_write && run_en), // frozen core never stores
        .store_data (exmem_q.store_data),
        .load_data  (load_data)
    );

    // read numbers sliced straight from IF/ID, keeps decode free of a loop
    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .we      (rf_we),
        .wr_num  (memwb_q.dest),
        .wr_data (wb_value),
        .rd_num  (ifid_instr[26:22]),
        .rs_num  (ifid_instr[21:17]),
        .rt_num  (ifid_instr[16:12]),
        .rd_val  (rf_rd_val),
        .rs_val  (rf_rs_val),
        .rt_val  (rf_rt_val)
    );

    decode_stage i_decode_stage (
        .instr        (ifid_instr),
        .pc           (ifid_pc),
        .rd_val       (rf_rd_val),
        .rs_val       (rf_rs_val),
        .rt_val       (rf_rt_val),
        .ex_load_dest (idex_q.rd),
        .ex_is_load   (idex_q.ctrl.mem_read),
        .fields       (id_fields),
        .stall        (stall),
        .taken        (taken),
        .target       (target)
    );

    execute_stage i_execute_stage (
        .idex         (idex_q),
        .exmem_dest   (exmem_q.dest),
        .memwb_dest   (memwb_q.dest),
        .exmem_wr     (exmem_q.ctrl.reg_write),
        .memwb_wr     (memwb_q.ctrl.reg_write),
        .exmem_result (exmem_q.result),
        .wb_value     (wb_value),
        .result       (ex_result),
        .store_data   (ex_store_data)
    );

    // writeback select
    assign wb_value = memwb_q.ctrl.mem_to_reg ? memwb_q.load_data : memwb_q.result;
    assign rf_we    = run_en && memwb_q.ctrl.reg_write;

    // one commit per architectural write, r0 writes dropped
    assign commit.valid = rf_we && (memwb_q.dest != '0);
    assign commit.dest  = memwb_q.dest;
    assign commit.value = wb_value;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_instr <= `TINKER_NOP;
            ifid_pc    <= '0;
            idex_q     <= '0;
            exmem_q    <= '0;
            memwb_q    <= '0;
        end else if (run_en) begin
            if (!stall) begin
                ifid_instr <= taken ? `TINKER_NOP : fetch_instr; // drop wrong-path fetch
                ifid_pc    <= pc;
            end
            idex_q <= (stall || taken) ? '0 : id_fields; // bubble
            exmem_q.ctrl       <= idex_q.ctrl;
            exmem_q.result     <= ex_result;
            exmem_q.store_data <= ex_store_data;
            exmem_q.dest       <= idex_q.rd;
            memwb_q.ctrl       <= exmem_q.ctrl;
            memwb_q.load_data  <= load_data;
            memwb_q.result     <= exmem_q.result;
            memwb_q.dest       <= exmem_q.dest;
        end
    end

endmodule

//--- source/tinker_pkg.sv
package tinker_pkg;

`include "tinker_defs.svh"

    typedef logic [`TINKER_DATA_W-1:0]  word_t;
    typedef logic [`TINKER_ADDR_W-1:0]  addr_t;
    typedef logic [`TINKER_REG_W-1:0]   reg_num_t;
    typedef logic [`TINKER_LIT_W-1:0]   literal_t;
    typedef logic [`TINKER_INSTR_W-1:0] instr_t;

    // only the kept instructions get names
    typedef enum logic [4:0] {
        op_and    = `TINKER_OP_AND,
        op_or     = `TINKER_OP_OR,
        op_xor    = `TINKER_OP_XOR,
        op_not    = `TINKER_OP_NOT,
        op_shftr  = `TINKER_OP_SHFTR,
        op_shftri = `TINKER_OP_SHFTRI,
        op_shftl  = `TINKER_OP_SHFTL,
        op_shftli = `TINKER_OP_SHFTLI,
        op_br     = `TINKER_OP_BR,
        op_brr_r  = `TINKER_OP_BRR_R,
        op_brr_l  = `TINKER_OP_BRR_L,
        op_brnz   = `TINKER_OP_BRNZ,
        op_brgt   = `TINKER_OP_BRGT,
        op_halt   = `TINKER_OP_HALT,
        op_load   = `TINKER_OP_LOAD,
        op_mov_rr = `TINKER_OP_MOV_RR,
        op_mov_rl = `TINKER_OP_MOV_RL,
        op_store  = `TINKER_OP_STORE,
        op_add    = `TINKER_OP_ADD,
        op_addi   = `TINKER_OP_ADDI,
        op_sub    = `TINKER_OP_SUB,
        op_subi   = `TINKER_OP_SUBI,
        op_mul    = `TINKER_OP_MUL
    } opcode_t;

    typedef enum logic [1:0] {
        load_s,
        run_s,
        halted_s
    } run_state_t;

    typedef struct packed {
        logic reg_write;  // rd written in WB
        logic mem_read;   // load in MEM
        logic mem_write;  // store in MEM
        logic mem_to_reg; // WB takes load data
        logic halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opcode_t  opcode;
        reg_num_t rd;
        reg_num_t rs;
        reg_num_t rt;
        literal_t literal;
        word_t    rd_val;
        word_t    rs_val;
        word_t    rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    result;     // ALU result or memory address
        word_t    store_data;
        reg_num_t dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    load_data;
        word_t    result;
        reg_num_t dest;
    } memwb_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;  // word index from the reset PC
        instr_t instr;
    } prog_write_t;

    typedef struct packed {
        logic     valid;
        reg_num_t dest;
        word_t    value;
    } commit_t;

endpackage

//--- source/unified_memory.sv
`timescale 1ns/1ps

`include "tinker_defs.svh"

module unified_memory import tinker_pkg::*; (
    input  logic        clk,
    input  prog_write_t prog,
    input  addr_t       fetch_addr,
    output instr_t      instr,
    input  addr_t       data_addr,
    input  logic        store_en,
    input  word_t       store_data,
    output word_t       load_data
);
    localparam int AW = $clog2(`TINKER_MEM_BYTES);

    typedef logic [AW-1:0] idx_t; // byte index, wraps at memory size

    logic [7:0] mem_bytes [`TINKER_MEM_BYTES];
    addr_t      prog_addr;
    idx_t       fetch_idx;
    idx_t       data_idx;
    idx_t       prog_idx;

    assign prog_addr = `TINKER_PC_RESET + (prog.addr << 2); // program image at reset PC
    assign fetch_idx = fetch_addr[AW-1:0];
    assign data_idx  = data_addr[AW-1:0];
    assign prog_idx  = prog_addr[AW-1:0];

    // little endian, lowest byte at the address
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            instr[8*k +: 8] = mem_bytes[fetch_idx + idx_t'(k)];
        end
        for (int k = 0; k < 8; k++) begin
            load_data[8*k +: 8] = mem_bytes[data_idx + idx_t'(k)];
        end
    end

    always_ff @(posedge clk) begin
        if (prog.valid) begin
            for (int k = 0; k < 4; k++) begin
                mem_bytes[prog_idx + idx_t'(k)] <= prog.instr[8*k +: 8];
            end
        end
        if (store_en) begin // full 8 byte store
            for (int k = 0; k < 8; k++) begin
                mem_bytes[data_idx + idx_t'(k)] <= store_data[8*k +: 8];
            end
        end
    end

    // loading happens only while the core is stopped
    a_no_store_during_load: assert property (@(posedge clk) !(prog.valid && store_en))
        else $error("store collides with program write");

endmodule
